//--- hdl/icb_bus_pkg.sv
////////////////////////////////////////////////////////////
// ICB bus definitions for the private peripheral slice
// Word types, device address map and the shared helpers
// for region decode and byte-masked register writes
////////////////////////////////////////////////////////////
`default_nettype none

package icb_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  wmask_t;
  typedef logic [19:0] region_t;
  typedef logic [11:0] offset_t;

  // Device regions, 4 KiB each
  localparam region_t ADDER_REGION = 20'h10041;
  localparam region_t GPIO_REGION  = 20'h10012;

  function automatic region_t addr_region(addr_t addr);
    return addr[31:12];
  endfunction

  function automatic offset_t addr_offset(addr_t addr);
    return addr[11:0];
  endfunction

  // Merge new bytes into a register under the write mask
  function automatic data_t apply_wmask(data_t old_val, data_t new_val, wmask_t mask);
    data_t merged;
    merged = old_val;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) merged[8*i +: 8] = new_val[8*i +: 8];
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- hdl/adder_pkg.sv
////////////////////////////////////////////////////////////
// Adder accelerator definitions
// Register map, control and status bits, operand word view
////////////////////////////////////////////////////////////
`default_nettype none

package adder_pkg;

  localparam icb_bus_pkg::offset_t ADDER_OPA_OFS    = 12'h000;
  localparam icb_bus_pkg::offset_t ADDER_OPB_OFS    = 12'h004;
  localparam icb_bus_pkg::offset_t ADDER_CTRL_OFS   = 12'h008;
  localparam icb_bus_pkg::offset_t ADDER_RESULT_OFS = 12'h00C;
  localparam icb_bus_pkg::offset_t ADDER_STATUS_OFS = 12'h010;

  // Control register
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_LANE_BIT  = 1;

  // Status register
  localparam int STATUS_DONE_BIT     = 0;
  localparam int STATUS_CARRY_HI_BIT = 1;
  localparam int STATUS_CARRY_LO_BIT = 2;
  localparam int STATUS_BUSY_BIT     = 3;

  typedef enum logic {ADD_FULL, ADD_LANES} add_mode_e;

  // One word seen whole or as two independent 16-bit lanes
  typedef union packed {
    logic [31:0] word;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } lanes;
  } add_word_u;

endpackage

`default_nettype wire

//--- hdl/icb_periph_fabric.sv
////////////////////////////////////////////////////////////
// Private peripheral ICB fabric
// Routes each command by region to the adder or GPIO-A and
// answers unmapped regions itself with an error response
////////////////////////////////////////////////////////////
`default_nettype none

module icb_periph_fabric (
  input  logic                hfclk,
  input  logic                rst,
  // Upstream port
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  icb_bus_pkg::addr_t  cmd_addr,
  input  logic                cmd_read,
  input  icb_bus_pkg::data_t  cmd_wdata,
  input  icb_bus_pkg::wmask_t cmd_wmask,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output logic                rsp_err,
  output icb_bus_pkg::data_t  rsp_rdata,
  // Adder port
  output logic                adder_cmd_valid,
  input  logic                adder_cmd_ready,
  output icb_bus_pkg::addr_t  adder_cmd_addr,
  output logic                adder_cmd_read,
  output icb_bus_pkg::data_t  adder_cmd_wdata,
  output icb_bus_pkg::wmask_t adder_cmd_wmask,
  input  logic                adder_rsp_valid,
  output logic                adder_rsp_ready,
  input  logic                adder_rsp_err,
  input  icb_bus_pkg::data_t  adder_rsp_rdata,
  // GPIO-A port
  output logic                gpio_cmd_valid,
  input  logic                gpio_cmd_ready,
  output icb_bus_pkg::addr_t  gpio_cmd_addr,
  output logic                gpio_cmd_read,
  output icb_bus_pkg::data_t  gpio_cmd_wdata,
  output icb_bus_pkg::wmask_t gpio_cmd_wmask,
  input  logic                gpio_rsp_valid,
  output logic                gpio_rsp_ready,
  input  logic                gpio_rsp_err,
  input  icb_bus_pkg::data_t  gpio_rsp_rdata
);
  import icb_bus_pkg::*;

  logic hit_adder;
  logic hit_gpio;
  logic pend_q;
  logic own_adder_q;
  logic own_gpio_q;

  assign hit_adder = (addr_region(cmd_addr) == ADDER_REGION);
  assign hit_gpio  = (addr_region(cmd_addr) == GPIO_REGION);

  ////////////////////////////////////////////////////////////
  // Command routing
  ////////////////////////////////////////////////////////////
  // Nothing new goes out while a response is pending
  assign adder_cmd_valid = cmd_valid && hit_adder && !pend_q;
  assign gpio_cmd_valid  = cmd_valid && hit_gpio && !pend_q;

  always_comb begin
    if (pend_q) cmd_ready = 1'b0;
    else if (hit_adder) cmd_ready = adder_cmd_ready;
    else if (hit_gpio) cmd_ready = gpio_cmd_ready;
    else cmd_ready = 1'b1;
  end

  assign adder_cmd_addr  = cmd_addr;
  assign adder_cmd_read  = cmd_read;
  assign adder_cmd_wdata = cmd_wdata;
  assign adder_cmd_wmask = cmd_wmask;
  assign gpio_cmd_addr   = cmd_addr;
  assign gpio_cmd_read   = cmd_read;
  assign gpio_cmd_wdata  = cmd_wdata;
  assign gpio_cmd_wmask  = cmd_wmask;

  // Owner of the outstanding response, neither means unmapped
  always_ff @(posedge hfclk) begin
    if (rst) begin
      pend_q      <= 1'b0;
      own_adder_q <= 1'b0;
      own_gpio_q  <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
      pend_q      <= 1'b1;
      own_adder_q <= hit_adder;
      own_gpio_q  <= hit_gpio;
    end else if (rsp_valid && rsp_ready) begin
      pend_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response return
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (own_adder_q) begin
      rsp_valid = pend_q && adder_rsp_valid;
      rsp_err   = adder_rsp_err;
      rsp_rdata = adder_rsp_rdata;
    end else if (own_gpio_q) begin
      rsp_valid = pend_q && gpio_rsp_valid;
      rsp_err   = gpio_rsp_err;
      rsp_rdata = gpio_rsp_rdata;
    end else begin
      // Unmapped region, one cycle after acceptance
      rsp_valid = pend_q;
      rsp_err   = 1'b1;
      rsp_rdata = '0;
    end
  end

  assign adder_rsp_ready = rsp_ready && pend_q && own_adder_q;
  assign gpio_rsp_ready  = rsp_ready && pend_q && own_gpio_q;

endmodule

`default_nettype wire

//--- hdl/adder_regs.sv
////////////////////////////////////////////////////////////
// Adder accelerator register block
// Operands, mode and start on ICB, result and status back
////////////////////////////////////////////////////////////
`default_nettype none

module adder_regs (
  input  logic                 hfclk,
  input  logic                 rst,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  icb_bus_pkg::addr_t   cmd_addr,
  input  logic                 cmd_read,
  input  icb_bus_pkg::data_t   cmd_wdata,
  input  icb_bus_pkg::wmask_t  cmd_wmask,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output logic                 rsp_err,
  output icb_bus_pkg::data_t   rsp_rdata,
  // Datapath op channel
  output logic                 op_valid,
  input  logic                 op_ready,
  output adder_pkg::add_word_u op_a,
  output adder_pkg::add_word_u op_b,
  output adder_pkg::add_mode_e op_mode,
  // Datapath result channel
  input  logic                 res_valid,
  output logic                 res_ready,
  input  adder_pkg::add_word_u res_sum,
  input  logic                 res_carry_hi,
  input  logic                 res_carry_lo
);
  import icb_bus_pkg::*;
  import adder_pkg::*;

  offset_t   ofs;
  data_t     rd_data;
  logic      acc_err;
  logic      wr_en;
  logic      start;
  add_word_u opa_q;
  add_word_u opb_q;
  add_word_u result_q;
  add_mode_e mode_q;
  logic      busy_q;
  logic      done_q;
  logic      carry_hi_q;
  logic      carry_lo_q;

  assign ofs       = addr_offset(cmd_addr);
  assign cmd_ready = !rsp_valid;
  assign wr_en     = cmd_valid && cmd_ready && !cmd_read && !acc_err;

  // Start is dropped while an add is in flight
  assign start = wr_en && (ofs == ADDER_CTRL_OFS) && cmd_wmask[0]
                 && cmd_wdata[CTRL_START_BIT] && !busy_q;

  ////////////////////////////////////////////////////////////
  // Register decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    rd_data = '0;
    acc_err = 1'b0;
    case (ofs)
      ADDER_OPA_OFS:  rd_data = opa_q.word;
      ADDER_OPB_OFS:  rd_data = opb_q.word;
      ADDER_CTRL_OFS: rd_data[CTRL_LANE_BIT] = (mode_q == ADD_LANES);
      ADDER_RESULT_OFS: begin
        rd_data = result_q.word;
        acc_err = !cmd_read;
      end
      ADDER_STATUS_OFS: begin
        rd_data[STATUS_DONE_BIT]     = done_q;
        rd_data[STATUS_CARRY_HI_BIT] = carry_hi_q;
        rd_data[STATUS_CARRY_LO_BIT] = carry_lo_q;
        rd_data[STATUS_BUSY_BIT]     = busy_q;
        acc_err = !cmd_read;
      end
      default: acc_err = 1'b1;
    endcase
  end

  always_ff @(posedge hfclk) begin
    if (rst) begin
      opa_q.word <= '0;
      opb_q.word <= '0;
      mode_q     <= ADD_FULL;
    end else if (wr_en) begin
      if (ofs == ADDER_OPA_OFS) opa_q.word <= apply_wmask(opa_q.word, cmd_wdata, cmd_wmask);
      if (ofs == ADDER_OPB_OFS) opb_q.word <= apply_wmask(opb_q.word, cmd_wdata, cmd_wmask);
      if (ofs == ADDER_CTRL_OFS && cmd_wmask[0]) begin
        mode_q <= cmd_wdata[CTRL_LANE_BIT] ? ADD_LANES : ADD_FULL;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath handshake
  ////////////////////////////////////////////////////////////
  always_ff @(posedge hfclk) begin
    if (rst) begin
      op_valid <= 1'b0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      if (start) op_valid <= 1'b1;
      else if (op_valid && op_ready) op_valid <= 1'b0;
      if (start) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (res_valid) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge hfclk) begin
    if (res_valid) begin
      result_q   <= res_sum;
      carry_hi_q <= res_carry_hi;
      carry_lo_q <= res_carry_lo;
    end
  end

  assign op_a      = opa_q;
  assign op_b      = opb_q;
  assign op_mode   = mode_q;
  assign res_ready = 1'b1;

  // Registered response, data is zero on writes and errors
  always_ff @(posedge hfclk) begin
    if (rst) rsp_valid <= 1'b0;
    else if (cmd_valid && cmd_ready) rsp_valid <= 1'b1;
    else if (rsp_ready) rsp_valid <= 1'b0;
  end

  always_ff @(posedge hfclk) begin
    if (cmd_valid && cmd_ready) begin
      rsp_err   <= acc_err;
      rsp_rdata <= (cmd_read && !acc_err) ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/adder_core.sv
////////////////////////////////////////////////////////////
// Adder datapath, one 32-bit sum or two 16-bit lane sums
// Holds one result until the register block takes it
////////////////////////////////////////////////////////////
`default_nettype none

module adder_core (
  input  logic                 hfclk,
  input  logic                 rst,
  input  logic                 op_valid,
  output logic                 op_ready,
  input  adder_pkg::add_word_u op_a,
  input  adder_pkg::add_word_u op_b,
  input  adder_pkg::add_mode_e op_mode,
  output logic                 res_valid,
  input  logic                 res_ready,
  output adder_pkg::add_word_u res_sum,
  output logic                 res_carry_hi,
  output logic                 res_carry_lo
);
  import adder_pkg::*;

  logic [32:0] full_sum;
  logic [16:0] hi_sum;
  logic [16:0] lo_sum;

  assign full_sum = {1'b0, op_a.word} + {1'b0, op_b.word};
  assign hi_sum   = {1'b0, op_a.lanes.hi} + {1'b0, op_b.lanes.hi};
  assign lo_sum   = {1'b0, op_a.lanes.lo} + {1'b0, op_b.lanes.lo};

  // Single result slot
  assign op_ready = !res_valid;

  always_ff @(posedge hfclk) begin
    if (rst) res_valid <= 1'b0;
    else if (op_valid && op_ready) res_valid <= 1'b1;
    else if (res_ready) res_valid <= 1'b0;
  end

  always_ff @(posedge hfclk) begin
    if (op_valid && op_ready) begin
      if (op_mode == ADD_LANES) begin
        res_sum.lanes.hi <= hi_sum[15:0];
        res_sum.lanes.lo <= lo_sum[15:0];
        res_carry_hi     <= hi_sum[16];
        res_carry_lo     <= lo_sum[16];
      end else begin
        res_sum.word <= full_sum[31:0];
        res_carry_hi <= full_sum[32];
        res_carry_lo <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/gpio_inspect.sv
////////////////////////////////////////////////////////////
// GPIO-A registers with the inspect-mode pad multiplexer
// Inspect mode drives all pads with a live view of the bus
////////////////////////////////////////////////////////////
`default_nettype none

module gpio_inspect (
  input  logic                hfclk,
  input  logic                rst,
  input  logic                inspect_mode,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  icb_bus_pkg::addr_t  cmd_addr,
  input  logic                cmd_read,
  input  icb_bus_pkg::data_t  cmd_wdata,
  input  icb_bus_pkg::wmask_t cmd_wmask,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output logic                rsp_err,
  output icb_bus_pkg::data_t  rsp_rdata,
  // Bus tap
  input  logic                tap_cmd_valid,
  input  logic                tap_cmd_ready,
  input  icb_bus_pkg::addr_t  tap_cmd_addr,
  input  logic                tap_rsp_valid,
  input  logic                tap_rsp_ready,
  // Pads
  input  icb_bus_pkg::data_t  gpio_a_ival,
  output icb_bus_pkg::data_t  gpio_a_oval,
  output icb_bus_pkg::data_t  gpio_a_oe
);
  import icb_bus_pkg::*;

  localparam offset_t GPIO_OVAL_OFS = 12'h000;
  localparam offset_t GPIO_OE_OFS   = 12'h004;
  localparam offset_t GPIO_IVAL_OFS = 12'h008;

  offset_t ofs;
  data_t   rd_data;
  logic    acc_err;
  logic    wr_en;
  data_t   oval_q;
  data_t   oe_q;
  data_t   inspect_view;

  assign ofs       = addr_offset(cmd_addr);
  assign cmd_ready = !rsp_valid;
  assign wr_en     = cmd_valid && cmd_ready && !cmd_read && !acc_err;

  // Input register is read only
  always_comb begin
    rd_data = '0;
    acc_err = 1'b0;
    case (ofs)
      GPIO_OVAL_OFS: rd_data = oval_q;
      GPIO_OE_OFS:   rd_data = oe_q;
      GPIO_IVAL_OFS: begin
        rd_data = gpio_a_ival;
        acc_err = !cmd_read;
      end
      default: acc_err = 1'b1;
    endcase
  end

  always_ff @(posedge hfclk) begin
    if (rst) begin
      oval_q <= '0;
      oe_q   <= '0;
    end else if (wr_en) begin
      if (ofs == GPIO_OVAL_OFS) oval_q <= apply_wmask(oval_q, cmd_wdata, cmd_wmask);
      if (ofs == GPIO_OE_OFS) oe_q <= apply_wmask(oe_q, cmd_wdata, cmd_wmask);
    end
  end

  always_ff @(posedge hfclk) begin
    if (rst) rsp_valid <= 1'b0;
    else if (cmd_valid && cmd_ready) rsp_valid <= 1'b1;
    else if (rsp_ready) rsp_valid <= 1'b0;
  end

  always_ff @(posedge hfclk) begin
    if (cmd_valid && cmd_ready) begin
      rsp_err   <= acc_err;
      rsp_rdata <= (cmd_read && !acc_err) ? rd_data : '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pad multiplexer
  ////////////////////////////////////////////////////////////
  // Address low bits, then the four handshake lines
  assign inspect_view = {6'b0, tap_rsp_ready, tap_rsp_valid,
                         tap_cmd_ready, tap_cmd_valid, tap_cmd_addr[21:0]};

  assign gpio_a_oe   = inspect_mode ? '1 : oe_q;
  assign gpio_a_oval = inspect_mode ? inspect_view : oval_q;

endmodule

`default_nettype wire

//--- hdl/subsys_main.sv
////////////////////////////////////////////////////////////
// Peripheral subsystem top
// ICB fabric with the adder accelerator and GPIO-A
////////////////////////////////////////////////////////////
`default_nettype none

module subsys_main (
  input  logic                hfclk,
  input  logic                rst,
  input  logic                inspect_mode,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  icb_bus_pkg::addr_t  cmd_addr,
  input  logic                cmd_read,
  input  icb_bus_pkg::data_t  cmd_wdata,
  input  icb_bus_pkg::wmask_t cmd_wmask,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output logic                rsp_err,
  output icb_bus_pkg::data_t  rsp_rdata,
  input  icb_bus_pkg::data_t  gpio_a_ival,
  output icb_bus_pkg::data_t  gpio_a_oval,
  output icb_bus_pkg::data_t  gpio_a_oe
);
  import icb_bus_pkg::*;
  import adder_pkg::*;

  // Adder device channels
  logic      adder_cmd_valid;
  logic      adder_cmd_ready;
  addr_t     adder_cmd_addr;
  logic      adder_cmd_read;
  data_t     adder_cmd_wdata;
  wmask_t    adder_cmd_wmask;
  logic      adder_rsp_valid;
  logic      adder_rsp_ready;
  logic      adder_rsp_err;
  data_t     adder_rsp_rdata;

  // GPIO-A device channels
  logic      gpio_cmd_valid;
  logic      gpio_cmd_ready;
  addr_t     gpio_cmd_addr;
  logic      gpio_cmd_read;
  data_t     gpio_cmd_wdata;
  wmask_t    gpio_cmd_wmask;
  logic      gpio_rsp_valid;
  logic      gpio_rsp_ready;
  logic      gpio_rsp_err;
  data_t     gpio_rsp_rdata;

  // Register block to datapath
  logic      op_valid;
  logic      op_ready;
  add_word_u op_a;
  add_word_u op_b;
  add_mode_e op_mode;
  logic      res_valid;
  logic      res_ready;
  add_word_u res_sum;
  logic      res_carry_hi;
  logic      res_carry_lo;

  icb_periph_fabric u_icb_periph_fabric (.*);

  adder_regs u_adder_regs (
    .cmd_valid (adder_cmd_valid),
    .cmd_ready (adder_cmd_ready),
    .cmd_addr  (adder_cmd_addr),
    .cmd_read  (adder_cmd_read),
    .cmd_wdata (adder_cmd_wdata),
    .cmd_wmask (adder_cmd_wmask),
    .rsp_valid (adder_rsp_valid),
    .rsp_ready (adder_rsp_ready),
    .rsp_err   (adder_rsp_err),
    .rsp_rdata (adder_rsp_rdata),
    .*
  );

  adder_core u_adder_core (.*);

  // Inspect view taps the upstream port
  gpio_inspect u_gpio_inspect (
    .cmd_valid     (gpio_cmd_valid),
    .cmd_ready     (gpio_cmd_ready),
    .cmd_addr      (gpio_cmd_addr),
    .cmd_read      (gpio_cmd_read),
    .cmd_wdata     (gpio_cmd_wdata),
    .cmd_wmask     (gpio_cmd_wmask),
    .rsp_valid     (gpio_rsp_valid),
    .rsp_ready     (gpio_rsp_ready),
    .rsp_err       (gpio_rsp_err),
    .rsp_rdata     (gpio_rsp_rdata),
    .tap_cmd_valid (cmd_valid),
    .tap_cmd_ready (cmd_ready),
    .tap_cmd_addr  (cmd_addr),
    .tap_rsp_valid (rsp_valid),
    .tap_rsp_ready (rsp_ready),
    .*
  );

endmodule

`default_nettype wire

//--- include/tb_icb_tasks.svh
////////////////////////////////////////////////////////////
// ICB driver and compare tasks for the subsystem testbench
// Expects hfclk, the top ICB signals, seed and err_count
////////////////////////////////////////////////////////////
`ifndef TB_ICB_TASKS_SVH
`define TB_ICB_TASKS_SVH

task automatic report_error(input string msg);
  err_count++;
  $display("Error at %0t: %s", $time, msg);
endtask

// One transfer, random rsp_ready stalls, response timing checked
task automatic icb_xfer(input icb_bus_pkg::addr_t addr, input logic read,
                        input icb_bus_pkg::data_t wdata, input icb_bus_pkg::wmask_t wmask,
                        output icb_bus_pkg::data_t rdata, output logic err);
  logic        accepted;
  logic        taken;
  logic [31:0] rnd;
  accepted = 1'b0;
  taken = 1'b0;
  cmd_valid <= 1'b1;
  cmd_addr  <= addr;
  cmd_read  <= read;
  cmd_wdata <= wdata;
  cmd_wmask <= wmask;
  while (!accepted) begin
    @(posedge hfclk);
    accepted = cmd_ready;
  end
  cmd_valid <= 1'b0;
  rnd = $random(seed);
  rsp_ready <= rnd[0];
  @(posedge hfclk);
  if (!rsp_valid) report_error($sformatf("no response one cycle after %h", addr));
  while (!taken) begin
    if (cmd_ready) report_error($sformatf("cmd_ready high with %h pending", addr));
    if (rsp_valid && rsp_ready) begin
      taken = 1'b1;
    end else begin
      rnd = $random(seed);
      rsp_ready <= rnd[0];
      @(posedge hfclk);
    end
  end
  rdata = rsp_rdata;
  err = rsp_err;
  rsp_ready <= 1'b0;
endtask

task automatic check_data(input icb_bus_pkg::data_t got, exp, input string what);
  if (got !== exp) report_error($sformatf("%s: got %h exp %h", what, got, exp));
endtask

task automatic check_err(input logic got, exp, input string what);
  if (got !== exp) report_error($sformatf("%s: rsp_err %b exp %b", what, got, exp));
endtask

task automatic check_word(input adder_pkg::add_word_u got, exp, input string what);
  if (got.word !== exp.word) begin
    report_error($sformatf("%s: lanes %h_%h exp %h_%h", what,
                           got.lanes.hi, got.lanes.lo, exp.lanes.hi, exp.lanes.lo));
  end
endtask

task automatic check_pads(input icb_bus_pkg::data_t oval, oe, exp_oval, exp_oe,
                          input string what);
  check_data(oval, exp_oval, {what, " gpio_a_oval"});
  check_data(oe, exp_oe, {what, " gpio_a_oe"});
endtask

`endif

//--- tb/tb_subsys_main.sv
////////////////////////////////////////////////////////////
// Testbench for the peripheral subsystem top
// Random ICB traffic to the adder and GPIO-A, checked
// against a register model kept here
////////////////////////////////////////////////////////////
`default_nettype none

module tb_subsys_main;
  timeunit 1ns;
  timeprecision 1ps;

  import icb_bus_pkg::*;
  import adder_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 5;
  localparam int NUM_OPS     = 150;
  // Worst case per op is an add with the full polling budget
  localparam int TXN_PER_OP  = 8;
  localparam int MAX_POLLS   = 4;
  localparam int WATCHDOG_NS = (NUM_OPS * TXN_PER_OP * 20 + RST_CYCLES) * CLK_PERIOD;

  localparam offset_t GPIO_OVAL_OFS = 12'h000;
  localparam offset_t GPIO_OE_OFS   = 12'h004;
  localparam offset_t GPIO_IVAL_OFS = 12'h008;

  logic   hfclk;
  logic   rst;
  logic   inspect_mode;
  logic   cmd_valid;
  logic   cmd_ready;
  addr_t  cmd_addr;
  logic   cmd_read;
  data_t  cmd_wdata;
  wmask_t cmd_wmask;
  logic   rsp_valid;
  logic   rsp_ready;
  logic   rsp_err;
  data_t  rsp_rdata;
  data_t  gpio_a_ival;
  data_t  gpio_a_oval;
  data_t  gpio_a_oe;

  integer seed = 32'h02b244f7;
  int     err_count;
  int     txn_count;

  // Model of opa, opb, oval and oe in that order
  data_t  model_val [4];
  addr_t  model_addr [4];

  `include "tb_icb_tasks.svh"

  subsys_main u_subsys_main (.*);

  initial begin
    hfclk = 1'b0;
    forever #(CLK_PERIOD / 2) hfclk = ~hfclk;
  end

  ////////////////////////////////////////////////////////////
  // Model helpers and stimulus tasks
  ////////////////////////////////////////////////////////////
  function automatic data_t merge_bytes(data_t old_val, data_t new_val, wmask_t mask);
    data_t byte_sel;
    byte_sel = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (old_val & ~byte_sel) | (new_val & byte_sel);
  endfunction

  task automatic bus_access(input addr_t addr, input logic read, input data_t wdata,
                            input wmask_t wmask, output data_t rdata, output logic err);
    txn_count++;
    icb_xfer(addr, read, wdata, wmask, rdata, err);
  endtask

  task automatic write_random_reg();
    int     idx;
    data_t  wdata;
    wmask_t wmask;
    data_t  rdata;
    logic   err;
    idx   = $unsigned($random(seed)) % 4;
    wdata = $random(seed);
    wmask = $random(seed);
    bus_access(model_addr[idx], 1'b0, wdata, wmask, rdata, err);
    check_err(err, 1'b0, $sformatf("write of register %0d", idx));
    model_val[idx] = merge_bytes(model_val[idx], wdata, wmask);
  endtask

  task automatic read_random_reg();
    int    idx;
    data_t rdata;
    logic  err;
    idx = $unsigned($random(seed)) % 4;
    bus_access(model_addr[idx], 1'b1, '0, '0, rdata, err);
    check_err(err, 1'b0, $sformatf("read of register %0d", idx));
    check_data(rdata, model_val[idx], $sformatf("rsp_rdata of register %0d", idx));
  endtask

  task automatic run_add(input add_mode_e mode);
    add_word_u   a;
    add_word_u   b;
    add_word_u   exp_sum;
    add_word_u   got;
    data_t       rdata;
    data_t       exp_status;
    logic        err;
    logic        done;
    logic        c_hi;
    logic        c_lo;
    int          polls;
    a.word = $random(seed);
    b.word = $random(seed);
    bus_access({ADDER_REGION, ADDER_OPA_OFS}, 1'b0, a.word, 4'hF, rdata, err);
    check_err(err, 1'b0, "operand A write");
    bus_access({ADDER_REGION, ADDER_OPB_OFS}, 1'b0, b.word, 4'hF, rdata, err);
    check_err(err, 1'b0, "operand B write");
    model_val[0] = a.word;
    model_val[1] = b.word;
    bus_access({ADDER_REGION, ADDER_CTRL_OFS}, 1'b0,
               {30'b0, mode == ADD_LANES, 1'b1}, 4'b0001, rdata, err);
    check_err(err, 1'b0, "control write");
    done  = 1'b0;
    polls = 0;
    while (!done && polls < MAX_POLLS) begin
      bus_access({ADDER_REGION, ADDER_STATUS_OFS}, 1'b1, '0, '0, rdata, err);
      done = rdata[STATUS_DONE_BIT];
      polls++;
    end
    if (!done) report_error("adder did not report done within the polling budget");
    // A carry out leaves the wrapped sum below either operand
    if (mode == ADD_LANES) begin
      exp_sum.lanes.hi = a.lanes.hi + b.lanes.hi;
      c_hi = (exp_sum.lanes.hi < a.lanes.hi);
      exp_sum.lanes.lo = a.lanes.lo + b.lanes.lo;
      c_lo = (exp_sum.lanes.lo < a.lanes.lo);
    end else begin
      exp_sum.word = a.word + b.word;
      c_hi = (exp_sum.word < a.word);
      c_lo = 1'b0;
    end
    exp_status = '0;
    exp_status[STATUS_DONE_BIT]     = 1'b1;
    exp_status[STATUS_CARRY_HI_BIT] = c_hi;
    exp_status[STATUS_CARRY_LO_BIT] = c_lo;
    check_data(rdata, exp_status, "rsp_rdata of adder status");
    bus_access({ADDER_REGION, ADDER_RESULT_OFS}, 1'b1, '0, '0, rdata, err);
    check_err(err, 1'b0, "result read");
    got.word = rdata;
    check_word(got, exp_sum,
               mode == ADD_LANES ? "rsp_rdata of lane result" : "rsp_rdata of full result");
  endtask

  // Unmapped region, unknown offsets and writes to read-only registers
  task automatic access_expect_error();
    logic [31:0] rnd;
    addr_t       addr;
    logic        read;
    data_t       rdata;
    logic        err;
    rnd  = $random(seed);
    addr = $random(seed);
    read = rnd[3];
    case (rnd[2:0] % 5)
      0: begin
        if (addr[31:12] == ADDER_REGION || addr[31:12] == GPIO_REGION) addr[31] = ~addr[31];
      end
      1: addr = {ADDER_REGION, {rnd[13:4], 2'b00} | 12'h014};
      2: addr = {GPIO_REGION, {rnd[13:4], 2'b00} | 12'h00C};
      3: begin
        addr = {ADDER_REGION, ADDER_RESULT_OFS};
        read = 1'b0;
      end
      default: begin
        addr = {ADDER_REGION, ADDER_STATUS_OFS};
        read = 1'b0;
      end
    endcase
    bus_access(addr, read, $random(seed), 4'hF, rdata, err);
    check_err(err, 1'b1, $sformatf("access to %h", addr));
    check_data(rdata, '0, $sformatf("rsp_rdata of error access to %h", addr));
  endtask

  task automatic read_input_pads();
    data_t pads;
    data_t rdata;
    logic  err;
    pads = $random(seed);
    gpio_a_ival <= pads;
    bus_access({GPIO_REGION, GPIO_IVAL_OFS}, 1'b1, '0, '0, rdata, err);
    check_err(err, 1'b0, "input register read");
    check_data(rdata, pads, "rsp_rdata of input register");
  endtask

  task automatic compare_pads_to_model();
    @(negedge hfclk);
    if (!inspect_mode) check_pads(gpio_a_oval, gpio_a_oe, model_val[2], model_val[3], "pads");
    @(posedge hfclk);
  endtask

  task automatic print_counts();
    $display("Summary: %0d transactions, %0d errors", txn_count, err_count);
  endtask

  // Live bus view on the pads while inspecting
  always @(negedge hfclk) begin
    data_t view;
    view        = '0;
    view[21:0]  = cmd_addr[21:0];
    view[22]    = cmd_valid;
    view[23]    = cmd_ready;
    view[24]    = rsp_valid;
    view[25]    = rsp_ready;
    if (!rst && inspect_mode) begin
      check_pads(gpio_a_oval, gpio_a_oe, view, '1, "inspect");
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] rnd;
    err_count = 0;
    txn_count = 0;
    model_addr[0] = {ADDER_REGION, ADDER_OPA_OFS};
    model_addr[1] = {ADDER_REGION, ADDER_OPB_OFS};
    model_addr[2] = {GPIO_REGION, GPIO_OVAL_OFS};
    model_addr[3] = {GPIO_REGION, GPIO_OE_OFS};
    for (int i = 0; i < 4; i++) begin
      model_val[i] = '0;
    end
    rst          = 1'b1;
    inspect_mode = 1'b0;
    cmd_valid    = 1'b0;
    cmd_addr     = '0;
    cmd_read     = 1'b0;
    cmd_wdata    = '0;
    cmd_wmask    = '0;
    rsp_ready    = 1'b0;
    gpio_a_ival  = '0;
    repeat (RST_CYCLES) @(posedge hfclk);
    rst <= 1'b0;
    @(posedge hfclk);
    if (!cmd_ready || rsp_valid) report_error("bus not idle after reset");
    for (int i = 0; i < NUM_OPS; i++) begin
      rnd = $random(seed);
      case (rnd[2:0])
        3'd0, 3'd1: write_random_reg();
        3'd2:       read_random_reg();
        3'd3, 3'd4: run_add(rnd[3] ? ADD_LANES : ADD_FULL);
        3'd5:       access_expect_error();
        3'd6:       read_input_pads();
        default:    inspect_mode <= rnd[4];
      endcase
      compare_pads_to_model();
    end
    print_counts();
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_error($sformatf("timeout, the test did not finish within %0d ns", WATCHDOG_NS));
    print_counts();
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hdl/icb_bus_pkg.sv
hdl/adder_pkg.sv
hdl/icb_periph_fabric.sv
hdl/adder_regs.sv
hdl/adder_core.sv
hdl/gpio_inspect.sv
hdl/subsys_main.sv
tb/tb_subsys_main.sv

//--- Bender.yml
package:
  name: subsys_main

sources:
  - hdl/icb_bus_pkg.sv
  - hdl/adder_pkg.sv
  - hdl/icb_periph_fabric.sv
  - hdl/adder_regs.sv
  - hdl/adder_core.sv
  - hdl/gpio_inspect.sv
  - hdl/subsys_main.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_subsys_main.sv
